// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and look for the pass line"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal -f flist.f \
		--top-module tb_exec_unit -Mdir obj_dir -o sim_exec_unit
	./obj_dir/sim_exec_unit 2>&1 | tee $(LOG)
	@grep -q "^TEST PASS$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: bench/exec_checker.sv
`timescale 1ns/1ns
`include "exec_settings.svh"

module exec_checker (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    issue_valid,
	input  logic                    issue_ready,
	input  logic [31:0]             issue_instr,
	input  logic [`EXEC_XLEN-1:0]   issue_pc,
	input  logic [`EXEC_XLEN-1:0]   issue_rs_val,
	input  logic [`EXEC_XLEN-1:0]   issue_rt_val,
	input  logic                    mem_credit,
	input  logic                    mem_valid,
	input  logic [`EXEC_XLEN-1:0]   mem_result,
	input  logic [`EXEC_XLEN-1:0]   mem_store_data,
	input  logic [4:0]              mem_wreg,
	input  logic [1:0]              mem_wb_src,
	input  logic                    mem_is_load,
	input  logic                    mem_is_store,
	input  logic [1:0]              mem_size_out,
	input  logic [1:0]              mem_t_new,
	output int                      checks,
	output int                      errors,
	output int                      pending,
	output logic                    timed_out
);
	import isa_pkg::*;
	import exec_pkg::*;

	localparam int TIMEOUT_CYCLES = 6000;

	typedef struct packed {
		logic [`EXEC_XLEN-1:0] result;
		logic [`EXEC_XLEN-1:0] store_data;
		logic [4:0]            wreg;
		logic [1:0]            wb_src;
		logic                  is_load;
		logic                  is_store;
		logic [1:0]            size;
		logic [1:0]            t_new;
		logic                  chk_result;
		logic                  chk_size;
	} bundle_t;

	bundle_t exp_q[$];
	string   name_q[$];
	int      acc_q[$];
	int      cycle;
	int      model_credits;

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	function automatic bundle_t expected_bundle(logic [31:0] w, logic [31:0] pc,
		logic [31:0] a, logic [31:0] b);
		bundle_t e;
		logic [31:0] se;
		logic [31:0] ze;
		se = {{16{w[15]}}, w[15:0]};
		ze = {16'h0, w[15:0]};
		e = '0;
		e.store_data = b;
		e.wb_src = WB_ALU;
		e.size = MEM_WORD;
		case (w[31:26])
			OP_SPECIAL: begin
				e.chk_result = 1'b1;
				e.wreg = w[15:11];
				case (w[5:0])
					FN_ADD:  e.result = a + b;
					FN_SUB:  e.result = a - b;
					FN_OR:   e.result = a | b;
					FN_AND:  e.result = a & b;
					FN_SLT:  e.result = {31'h0, $signed(a) < $signed(b)};
					FN_SLTU: e.result = {31'h0, a < b};
					default: begin
						e.chk_result = 1'b0;
						e.wreg = 5'd0;
					end
				endcase
			end
			OP_ADDI, OP_ORI, OP_ANDI, OP_LUI: begin
				e.chk_result = 1'b1;
				e.wreg = w[20:16];
				if (w[31:26] == OP_ADDI)
					e.result = a + se;
				else if (w[31:26] == OP_ORI)
					e.result = a | ze;
				else if (w[31:26] == OP_ANDI)
					e.result = a & ze;
				else
					e.result = {w[15:0], 16'h0};
			end
			OP_LW, OP_LH, OP_LB, OP_SW, OP_SH, OP_SB: begin
				e.chk_result = 1'b1;
				e.chk_size = 1'b1;
				e.result = a + se;
				e.is_load = !w[29];
				e.is_store = w[29];
				if (!w[29]) begin
					e.wreg = w[20:16];
					e.wb_src = WB_MEM;
					e.t_new = 2'd1;
				end
				if (w[31:26] == OP_LH || w[31:26] == OP_SH)
					e.size = MEM_HALF;
				else if (w[31:26] == OP_LB || w[31:26] == OP_SB)
					e.size = MEM_BYTE;
			end
			OP_JAL: begin
				e.chk_result = 1'b1;
				e.result = pc + 32'd8;
				e.wreg = 5'd31;
				e.wb_src = WB_LINK;
			end
			default: ;
		endcase
		return e;
	endfunction

	function automatic string instr_name(logic [31:0] w);
		string s;
		s = $sformatf("op%02h_fn%02h", w[31:26], w[5:0]);
		return s;
	endfunction

	task automatic check_field(string test, string field, logic [31:0] exp_v,
		logic [31:0] act_v);
		if (exp_v !== act_v) begin
			errors++;
			$display("CHECK FAILED %s %s: expected %h actual %h", test, field, exp_v, act_v);
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Compare, credit tracking and timeout
	//////////////////////////////////////////////////////////////////////

	initial begin
		checks = 0;
		errors = 0;
		pending = 0;
		timed_out = 1'b0;
		cycle = 0;
		model_credits = `EXEC_CREDITS;
	end

	always @(posedge clk) begin
		bundle_t e;
		string   nm;
		int      acc;
		if (!arst_n) begin
			model_credits = `EXEC_CREDITS;
		end else begin
			cycle++;
			// First edge after reset release
			if (cycle == 1 && (mem_valid !== 1'b0 || issue_ready !== 1'b1)) begin
				errors++;
				$display("After reset mem_valid was not low or issue_ready was not high");
			end
			if (cycle == TIMEOUT_CYCLES && !timed_out) begin
				timed_out = 1'b1;
				$display("Run stalled: %0d bundles still outstanding after %0d cycles",
					pending, cycle);
			end
			if (issue_ready !== (model_credits != 0)) begin
				errors++;
				$display("issue_ready is %b while the model holds %0d credits",
					issue_ready, model_credits);
			end
			if (mem_valid) begin
				if (exp_q.size() == 0) begin
					errors++;
					$display("A bundle arrived with no instruction accepted for it");
				end else begin
					e = exp_q.pop_front();
					nm = name_q.pop_front();
					acc = acc_q.pop_front();
					checks++;
					if (acc + 1 != cycle) begin
						errors++;
						$display("Bundle for %s arrived %0d cycles after acceptance",
							nm, cycle - acc);
					end
					if (e.chk_result)
						check_field(nm, "result", e.result, mem_result);
					check_field(nm, "store_data", e.store_data, mem_store_data);
					check_field(nm, "wreg", e.wreg, mem_wreg);
					check_field(nm, "wb_src", e.wb_src, mem_wb_src);
					check_field(nm, "is_load", e.is_load, mem_is_load);
					check_field(nm, "is_store", e.is_store, mem_is_store);
					if (e.chk_size)
						check_field(nm, "size", e.size, mem_size_out);
					check_field(nm, "t_new", e.t_new, mem_t_new);
				end
			end
			if (issue_valid && issue_ready) begin
				exp_q.push_back(expected_bundle(issue_instr, issue_pc, issue_rs_val,
					issue_rt_val));
				name_q.push_back(instr_name(issue_instr));
				acc_q.push_back(cycle);
				model_credits--;
			end
			if (mem_credit)
				model_credits++;
			if (model_credits < 0 || model_credits > `EXEC_CREDITS) begin
				errors++;
				$display("Credit count left its range, now %0d", model_credits);
			end
			pending = exp_q.size() + (`EXEC_CREDITS - model_credits);
		end
	end

endmodule

// File: bench/tb_exec_unit.sv
`timescale 1ns/1ns
`include "exec_settings.svh"

module tb_exec_unit;
	import isa_pkg::*;
	import exec_pkg::*;

	localparam int NUM_INSTR = 400;

	logic                  clk;
	logic                  arst_n;
	logic                  issue_valid;
	logic [31:0]           issue_instr;
	logic [`EXEC_XLEN-1:0] issue_pc;
	logic [`EXEC_XLEN-1:0] issue_rs_val;
	logic [`EXEC_XLEN-1:0] issue_rt_val;
	logic                  mem_credit;
	logic                  issue_ready;
	logic                  mem_valid;
	logic [`EXEC_XLEN-1:0] mem_result;
	logic [`EXEC_XLEN-1:0] mem_store_data;
	logic [4:0]            mem_wreg;
	wb_src_e               mem_wb_src;
	logic                  mem_is_load;
	logic                  mem_is_store;
	mem_size_e             mem_size_out;
	logic [1:0]            mem_t_new;
	int                    checks;
	int                    errors;
	int                    pending;
	logic                  timed_out;
	int                    cyc;
	int                    due_q[$];

	exec_unit dut (
		.clk(clk), .arst_n(arst_n), .issue_valid(issue_valid),
		.issue_instr(issue_instr), .issue_pc(issue_pc),
		.issue_rs_val(issue_rs_val), .issue_rt_val(issue_rt_val),
		.mem_credit(mem_credit), .issue_ready(issue_ready), .mem_valid(mem_valid),
		.mem_result(mem_result), .mem_store_data(mem_store_data), .mem_wreg(mem_wreg),
		.mem_wb_src(mem_wb_src), .mem_is_load(mem_is_load), .mem_is_store(mem_is_store),
		.mem_size_out(mem_size_out), .mem_t_new(mem_t_new)
	);

	exec_checker u_checker (
		.clk(clk), .arst_n(arst_n), .issue_valid(issue_valid), .issue_ready(issue_ready),
		.issue_instr(issue_instr), .issue_pc(issue_pc), .issue_rs_val(issue_rs_val),
		.issue_rt_val(issue_rt_val), .mem_credit(mem_credit), .mem_valid(mem_valid),
		.mem_result(mem_result), .mem_store_data(mem_store_data), .mem_wreg(mem_wreg),
		.mem_wb_src(mem_wb_src), .mem_is_load(mem_is_load), .mem_is_store(mem_is_store),
		.mem_size_out(mem_size_out), .mem_t_new(mem_t_new), .checks(checks),
		.errors(errors), .pending(pending), .timed_out(timed_out)
	);

	always #10 clk = ~clk;

	// Random word with opcode and funct picked from the covered set
	function automatic logic [31:0] random_instr();
		logic [31:0] w;
		int          k;
		w = $urandom;
		k = $urandom_range(0, 21);
		case (k)
			0, 1, 2, 3, 4, 5, 6: w[31:26] = OP_SPECIAL;
			7:  w[31:26] = OP_ADDI;
			8:  w[31:26] = OP_ORI;
			9:  w[31:26] = OP_ANDI;
			10: w[31:26] = OP_LUI;
			11: w[31:26] = OP_LW;
			12: w[31:26] = OP_LH;
			13: w[31:26] = OP_LB;
			14: w[31:26] = OP_SW;
			15: w[31:26] = OP_SH;
			16: w[31:26] = OP_SB;
			17: w[31:26] = OP_BEQ;
			18: w[31:26] = OP_BNE;
			19: w[31:26] = OP_JAL;
			// Unlisted encodings, one opcode and one funct
			20: w[31:26] = 6'h3f;
			default: begin
				w[31:26] = OP_SPECIAL;
				w[5:0] = 6'h01;
			end
		endcase
		case (k)
			0: w[5:0] = FN_ADD;
			1: w[5:0] = FN_SUB;
			2: w[5:0] = FN_OR;
			3: w[5:0] = FN_AND;
			4: w[5:0] = FN_SLT;
			5: w[5:0] = FN_SLTU;
			6: w[5:0] = FN_JR;
			default: ;
		endcase
		return w;
	endfunction

	//////////////////////////////////////////////////////////////////////
	// Memory stage credit model
	//////////////////////////////////////////////////////////////////////

	always @(posedge clk) begin
		cyc++;
		#1;
		mem_credit = 1'b0;
		if (due_q.size() > 0 && cyc >= due_q[0]) begin
			mem_credit = 1'b1;
			void'(due_q.pop_front());
		end
	end

	always @(negedge clk) begin
		int d;
		int t;
		if (arst_n && mem_valid) begin
			d = $urandom_range(0, 7);
			// Occasional long stall
			if ($urandom_range(0, 29) == 0)
				d += 20 + $urandom_range(0, 20);
			t = cyc + 1 + d;
			if (due_q.size() > 0 && t <= due_q[$])
				t = due_q[$] + 1;
			due_q.push_back(t);
		end
	end

	initial begin
		int n;
		void'($urandom(32'hc9b2));
		clk = 1'b0;
		cyc = 0;
		arst_n = 1'b0;
		issue_valid = 1'b0;
		issue_instr = '0;
		issue_pc = '0;
		issue_rs_val = '0;
		issue_rt_val = '0;
		mem_credit = 1'b0;
		repeat (2) @(posedge clk);
		#1 arst_n = 1'b1;
		n = 0;
		while (n < NUM_INSTR && !timed_out) begin
			@(posedge clk);
			#1;
			issue_valid = ($urandom_range(0, 9) != 0);
			issue_instr = random_instr();
			issue_pc = $urandom & ~32'h3;
			issue_rs_val = $urandom;
			issue_rt_val = ($urandom_range(0, 7) == 0) ? issue_rs_val : $urandom;
			@(negedge clk);
			if (issue_valid && issue_ready)
				n++;
		end
		@(posedge clk);
		#1 issue_valid = 1'b0;
		while (pending != 0 && !timed_out)
			@(posedge clk);
		repeat (2) @(posedge clk);
		$display("Checks %0d, errors %0d", checks, errors);
		if (errors == 0 && !timed_out)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

// File: flist.f
+incdir+logic
logic/isa_pkg.sv
logic/exec_pkg.sv
logic/exec_decoder.sv
logic/exec_alu.sv
logic/exec_mem_port.sv
logic/exec_unit.sv
bench/exec_checker.sv
bench/tb_exec_unit.sv

// File: logic/exec_alu.sv
`timescale 1ns/1ns
`include "exec_settings.svh"

module exec_alu (
	input  exec_pkg::alu_op_e       alu_op,
	input  exec_pkg::b_src_e        b_src,
	input  logic [15:0]             imm16,
	input  logic [`EXEC_XLEN-1:0]   rs_val,
	input  logic [`EXEC_XLEN-1:0]   rt_val,
	input  logic [`EXEC_XLEN-1:0]   pc,
	output logic [`EXEC_XLEN-1:0]   result,
	output logic [`EXEC_XLEN-1:0]   link
);
	import exec_pkg::*;

	logic [`EXEC_XLEN-1:0] op_b;
	logic                  lt_signed;
	logic                  lt_unsigned;

	// Operand B select
	always_comb begin
		case (b_src)
			B_SEXT:  op_b = {{(`EXEC_XLEN-16){imm16[15]}}, imm16};
			B_ZEXT:  op_b = {{(`EXEC_XLEN-16){1'b0}}, imm16};
			default: op_b = rt_val;
		endcase
	end

	assign lt_signed   = $signed(rs_val) < $signed(op_b);
	assign lt_unsigned = rs_val < op_b;

	//////////////////////////////////////////////////////////////////////
	// Function unit
	//////////////////////////////////////////////////////////////////////

	always_comb begin
		case (alu_op)
			ALU_ADD:  result = rs_val + op_b;
			ALU_SUB:  result = rs_val - op_b;
			ALU_OR:   result = rs_val | op_b;
			ALU_AND:  result = rs_val & op_b;
			// Upper half immediate, lower half cleared
			ALU_LUI:  result = {op_b[15:0], {(`EXEC_XLEN-16){1'b0}}};
			ALU_SLT:  result = {{(`EXEC_XLEN-1){1'b0}}, lt_signed};
			ALU_SLTU: result = {{(`EXEC_XLEN-1){1'b0}}, lt_unsigned};
			default:  result = '0;
		endcase
	end

	// Return address skips the delay slot
	assign link = pc + {{(`EXEC_XLEN-4){1'b0}}, 4'd8};

endmodule

// File: logic/exec_decoder.sv
`timescale 1ns/1ns

module exec_decoder (
	input  isa_pkg::instr_u      instr,
	output logic [15:0]          imm16,
	output exec_pkg::alu_op_e    alu_op,
	output exec_pkg::b_src_e     b_src,
	output exec_pkg::wb_src_e    wb_src,
	output logic [4:0]           wreg,
	output logic                 is_load,
	output logic                 is_store,
	output exec_pkg::mem_size_e  mem_size,
	output logic [1:0]           t_new
);
	import isa_pkg::*;
	import exec_pkg::*;

	logic special;
	logic i_add, i_sub, i_or, i_and, i_slt, i_sltu;
	logic i_addi, i_ori, i_andi, i_lui;
	logic i_lw, i_lh, i_lb, i_sw, i_sh, i_sb;
	logic i_jal;
	logic r_alu;
	logic imm_alu;

	//////////////////////////////////////////////////////////////////////
	// Instruction match
	//////////////////////////////////////////////////////////////////////

	assign special = (instr.r.opcode == OP_SPECIAL);

	// R-format group, selected by funct
	assign i_add  = special && (instr.r.funct == FN_ADD);
	assign i_sub  = special && (instr.r.funct == FN_SUB);
	assign i_or   = special && (instr.r.funct == FN_OR);
	assign i_and  = special && (instr.r.funct == FN_AND);
	assign i_slt  = special && (instr.r.funct == FN_SLT);
	assign i_sltu = special && (instr.r.funct == FN_SLTU);

	assign i_addi = (instr.i.opcode == OP_ADDI);
	assign i_ori  = (instr.i.opcode == OP_ORI);
	assign i_andi = (instr.i.opcode == OP_ANDI);
	assign i_lui  = (instr.i.opcode == OP_LUI);
	assign i_lw   = (instr.i.opcode == OP_LW);
	assign i_lh   = (instr.i.opcode == OP_LH);
	assign i_lb   = (instr.i.opcode == OP_LB);
	assign i_sw   = (instr.i.opcode == OP_SW);
	assign i_sh   = (instr.i.opcode == OP_SH);
	assign i_sb   = (instr.i.opcode == OP_SB);
	assign i_jal  = (instr.i.opcode == OP_JAL);

	assign r_alu   = i_add || i_sub || i_or || i_and || i_slt || i_sltu;
	assign imm_alu = i_addi || i_ori || i_andi || i_lui;

	assign is_load  = i_lw || i_lh || i_lb;
	assign is_store = i_sw || i_sh || i_sb;

	//////////////////////////////////////////////////////////////////////
	// Control outputs
	//////////////////////////////////////////////////////////////////////

	assign imm16 = instr.i.imm16;

	// Address arithmetic shares the adder with add and addi
	always_comb begin
		if (i_sub)
			alu_op = ALU_SUB;
		else if (i_or || i_ori)
			alu_op = ALU_OR;
		else if (i_and || i_andi)
			alu_op = ALU_AND;
		else if (i_lui)
			alu_op = ALU_LUI;
		else if (i_slt)
			alu_op = ALU_SLT;
		else if (i_sltu)
			alu_op = ALU_SLTU;
		else
			alu_op = ALU_ADD;
	end

	assign b_src = (i_addi || is_load || is_store) ? B_SEXT :
	               (i_ori || i_andi || i_lui)      ? B_ZEXT : B_RT;

	assign wb_src = i_jal ? WB_LINK : is_load ? WB_MEM : WB_ALU;

	assign wreg = r_alu               ? instr.r.rd :
	              (imm_alu || is_load) ? instr.i.rt :
	              i_jal               ? 5'd31 : 5'd0;

	assign mem_size = (i_lh || i_sh) ? MEM_HALF :
	                  (i_lb || i_sb) ? MEM_BYTE : MEM_WORD;

	// ALU results are ready after execute, loads after memory
	assign t_new = (r_alu || imm_alu) ? 2'd1 :
	               is_load            ? 2'd2 : 2'd0;

endmodule

// File: logic/exec_mem_port.sv
`timescale 1ns/1ns
`include "exec_settings.svh"

module exec_mem_port (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    issue_valid,
	input  logic [`EXEC_XLEN-1:0]   result,
	input  logic [`EXEC_XLEN-1:0]   link,
	input  logic [`EXEC_XLEN-1:0]   store_data,
	input  logic [4:0]              wreg,
	input  exec_pkg::wb_src_e       wb_src,
	input  logic                    is_load,
	input  logic                    is_store,
	input  exec_pkg::mem_size_e     mem_size,
	input  logic [1:0]              t_new,
	input  logic                    mem_credit,
	output logic                    issue_ready,
	output logic                    mem_valid,
	output logic [`EXEC_XLEN-1:0]   mem_result,
	output logic [`EXEC_XLEN-1:0]   mem_store_data,
	output logic [4:0]              mem_wreg,
	output exec_pkg::wb_src_e       mem_wb_src,
	output logic                    mem_is_load,
	output logic                    mem_is_store,
	output exec_pkg::mem_size_e     mem_size_out,
	output logic [1:0]              mem_t_new
);
	import exec_pkg::*;

	localparam int CW = $clog2(`EXEC_CREDITS + 1);

	logic [CW-1:0] credits;
	logic          fire;

	assign issue_ready = (credits != '0);
	assign fire        = issue_valid && issue_ready;

	//////////////////////////////////////////////////////////////////////
	// Credit counter and valid
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			credits   <= CW'(`EXEC_CREDITS);
			mem_valid <= 1'b0;
		end else begin
			mem_valid <= fire;
			// Send and return together cancel out
			if (fire && !mem_credit)
				credits <= credits - CW'(1);
			else if (mem_credit && !fire)
				credits <= credits + CW'(1);
		end
	end

	// Bundle payload
	always_ff @(posedge clk) begin
		if (fire) begin
			mem_result     <= (wb_src == WB_LINK) ? link : result;
			mem_store_data <= store_data;
			mem_wreg       <= wreg;
			mem_wb_src     <= wb_src;
			mem_is_load    <= is_load;
			mem_is_store   <= is_store;
			mem_size_out   <= mem_size;
			mem_t_new      <= (t_new == 2'd0) ? 2'd0 : t_new - 2'd1;
		end
	end

	a_credit_bound: assert property (@(posedge clk) disable iff (!arst_n)
		credits <= CW'(`EXEC_CREDITS));

	// Memory stage never returns more than it was sent
	a_no_extra_credit: assert property (@(posedge clk) disable iff (!arst_n)
		mem_credit |-> credits != CW'(`EXEC_CREDITS));

endmodule

// File: logic/exec_pkg.sv
package exec_pkg;

	// ALU function select
	typedef enum logic [2:0] {
		ALU_ADD  = 3'b000,
		ALU_SUB  = 3'b001,
		ALU_OR   = 3'b010,
		ALU_LUI  = 3'b011,
		ALU_SLT  = 3'b100,
		ALU_SLTU = 3'b101,
		ALU_AND  = 3'b110
	} alu_op_e;

	// Second operand source
	typedef enum logic [1:0] {
		B_RT   = 2'b00,
		B_SEXT = 2'b01,
		B_ZEXT = 2'b10
	} b_src_e;

	// What the register file gets written with
	typedef enum logic [1:0] {
		WB_ALU  = 2'b00,
		WB_MEM  = 2'b01,
		WB_LINK = 2'b10
	} wb_src_e;

	// Load and store access size
	typedef enum logic [1:0] {
		MEM_WORD = 2'b00,
		MEM_HALF = 2'b01,
		MEM_BYTE = 2'b10
	} mem_size_e;

endpackage

// File: logic/exec_settings.svh
`ifndef EXEC_SETTINGS_SVH
`define EXEC_SETTINGS_SVH

// Data word width
`define EXEC_XLEN 32

// Bundles the memory stage can buffer
`define EXEC_CREDITS 4

`endif

// File: logic/exec_unit.sv
`timescale 1ns/1ns
`include "exec_settings.svh"

module exec_unit (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    issue_valid,
	input  isa_pkg::instr_u         issue_instr,
	input  logic [`EXEC_XLEN-1:0]   issue_pc,
	input  logic [`EXEC_XLEN-1:0]   issue_rs_val,
	input  logic [`EXEC_XLEN-1:0]   issue_rt_val,
	input  logic                    mem_credit,
	output logic                    issue_ready,
	output logic                    mem_valid,
	output logic [`EXEC_XLEN-1:0]   mem_result,
	output logic [`EXEC_XLEN-1:0]   mem_store_data,
	output logic [4:0]              mem_wreg,
	output exec_pkg::wb_src_e       mem_wb_src,
	output logic                    mem_is_load,
	output logic                    mem_is_store,
	output exec_pkg::mem_size_e     mem_size_out,
	output logic [1:0]              mem_t_new
);
	import exec_pkg::*;

	logic [15:0]           imm16;
	alu_op_e               alu_op;
	b_src_e                b_src;
	wb_src_e               wb_src;
	logic [4:0]            wreg;
	logic                  is_load;
	logic                  is_store;
	mem_size_e             mem_size;
	logic [1:0]            t_new;
	logic [`EXEC_XLEN-1:0] result;
	logic [`EXEC_XLEN-1:0] link;

	exec_decoder u_decoder (
		.instr    (issue_instr),
		.imm16    (imm16),
		.alu_op   (alu_op),
		.b_src    (b_src),
		.wb_src   (wb_src),
		.wreg     (wreg),
		.is_load  (is_load),
		.is_store (is_store),
		.mem_size (mem_size),
		.t_new    (t_new)
	);

	exec_alu u_alu (
		.alu_op (alu_op),
		.b_src  (b_src),
		.imm16  (imm16),
		.rs_val (issue_rs_val),
		.rt_val (issue_rt_val),
		.pc     (issue_pc),
		.result (result),
		.link   (link)
	);

	// Store data is the rt register value as read at issue
	exec_mem_port u_mem_port (
		.clk            (clk),
		.arst_n         (arst_n),
		.issue_valid    (issue_valid),
		.result         (result),
		.link           (link),
		.store_data     (issue_rt_val),
		.wreg           (wreg),
		.wb_src         (wb_src),
		.is_load        (is_load),
		.is_store       (is_store),
		.mem_size       (mem_size),
		.t_new          (t_new),
		.mem_credit     (mem_credit),
		.issue_ready    (issue_ready),
		.mem_valid      (mem_valid),
		.mem_result     (mem_result),
		.mem_store_data (mem_store_data),
		.mem_wreg       (mem_wreg),
		.mem_wb_src     (mem_wb_src),
		.mem_is_load    (mem_is_load),
		.mem_is_store   (mem_is_store),
		.mem_size_out   (mem_size_out),
		.mem_t_new      (mem_t_new)
	);

endmodule

// File: logic/isa_pkg.sv
package isa_pkg;

	//////////////////////////////////////////////////////////////////////
	// Instruction word views
	//////////////////////////////////////////////////////////////////////

	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} instr_r_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm16;
	} instr_i_t;

	// Same 32 bits, read as either format
	typedef union packed {
		instr_r_t r;
		instr_i_t i;
	} instr_u;

	//////////////////////////////////////////////////////////////////////
	// Encodings
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [5:0] {
		OP_SPECIAL = 6'b000000,
		OP_JAL     = 6'b000011,
		OP_BEQ     = 6'b000100,
		OP_BNE     = 6'b000101,
		OP_ADDI    = 6'b001000,
		OP_ANDI    = 6'b001100,
		OP_ORI     = 6'b001101,
		OP_LUI     = 6'b001111,
		OP_LB      = 6'b100000,
		OP_LH      = 6'b100001,
		OP_LW      = 6'b100011,
		OP_SB      = 6'b101000,
		OP_SH      = 6'b101001,
		OP_SW      = 6'b101011
	} opcode_e;

	// Funct field, only meaningful under OP_SPECIAL
	typedef enum logic [5:0] {
		FN_JR   = 6'b001000,
		FN_ADD  = 6'b100000,
		FN_SUB  = 6'b100010,
		FN_AND  = 6'b100100,
		FN_OR   = 6'b100101,
		FN_SLT  = 6'b101010,
		FN_SLTU = 6'b101011
	} funct_e;

endpackage
